/* Makefile */
# Verilator build and run of the SoC harness testbench

TOP := tb_soc_harness

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f soc_harness.f \
		--top-module $(TOP) -o V$(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall -f soc_harness.f --top-module soc_harness

clean:
	rm -rf obj_dir

/* hdl/boot_rom.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_harness_cfg.svh"

module boot_rom (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  soc_harness_pkg::addr_t addr_i,
  output soc_harness_pkg::data_t rdata_o
);

  // Byte offset bits below the word index
  localparam int unsigned off_w = $clog2(`DATA_W / 8);

  soc_harness_pkg::rom_idx_t rom_idx;
  soc_harness_pkg::data_t    rom_table [`ROM_WORDS];
  soc_harness_pkg::data_t    rdata_q;

  // Wraps every ROM_WORDS words across the region
  assign rom_idx = addr_i[off_w +: $bits(soc_harness_pkg::rom_idx_t)];

  // ----------------------------------------
  // Fixed contents
  // ----------------------------------------
  // Signature in the upper half, word number in the lower half
  always_comb begin
    for (int k = 0; k < `ROM_WORDS; k++) begin
      rom_table[k] = {32'(`ROM_SIG), 32'(k)};
    end
  end

  // Registered read
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rom_table[rom_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hdl/bus_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_harness_cfg.svh"

module bus_addr_decode (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   we_i,
  input  soc_harness_pkg::addr_t addr_i,
  input  soc_harness_pkg::data_t rom_rdata_i,
  input  soc_harness_pkg::data_t sram_rdata_i,
  output logic                   rom_req_o,
  output logic                   sram_req_o,
  output logic                   rsp_valid_o,
  output logic                   rsp_err_o,
  output soc_harness_pkg::data_t rdata_o
);

  // Region bounds, end addresses exclusive
  localparam soc_harness_pkg::addr_t rom_base  = `ROM_BASE;
  localparam soc_harness_pkg::addr_t rom_end   = `ROM_BASE + `ROM_LEN;
  localparam soc_harness_pkg::addr_t sram_base = `SRAM_BASE;
  localparam soc_harness_pkg::addr_t sram_end  = `SRAM_BASE + (`SRAM_WORDS * `STRB_W);

  soc_harness_pkg::region_e region_d;
  soc_harness_pkg::region_e region_q;
  logic                     req_acc;
  logic                     we_q;
  logic                     valid_q;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  // GPIO and anything else falls through to REGION_NONE
  always_comb begin
    region_d = soc_harness_pkg::REGION_NONE;
    if (addr_i >= rom_base && addr_i < rom_end) begin
      region_d = soc_harness_pkg::REGION_ROM;
    end else if (addr_i >= sram_base && addr_i < sram_end) begin
      region_d = soc_harness_pkg::REGION_SRAM;
    end
  end

  // Requests are only taken once the system is out of reset
  assign req_acc = req_i & rst_ni;

  // ROM is read-only so writes never reach it
  assign rom_req_o  = req_acc & ~we_i & (region_d == soc_harness_pkg::REGION_ROM);
  assign sram_req_o = req_acc & (region_d == soc_harness_pkg::REGION_SRAM);

  // ----------------------------------------
  // Response pipeline
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      region_q <= soc_harness_pkg::REGION_NONE;
    end else begin
      valid_q <= req_acc;
      if (req_acc) begin
        we_q     <= we_i;
        region_q <= region_d;
      end
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_err_o   = valid_q & (region_q == soc_harness_pkg::REGION_NONE);

  // Read data from the slave picked last cycle, zero for writes and errors
  always_comb begin
    rdata_o = '0;
    if (valid_q && !we_q) begin
      case (region_q)
        soc_harness_pkg::REGION_ROM:  rdata_o = rom_rdata_i;
        soc_harness_pkg::REGION_SRAM: rdata_o = sram_rdata_i;
        default:                      rdata_o = '0;
      endcase
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_one_slave : assert property (
    @(posedge clk_i) !(rom_req_o && sram_req_o)
  );

  // Fixed one-cycle latency, no back-pressure
  a_rsp_next_cycle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |=> rsp_valid_o
  );

endmodule

`default_nettype wire

/* hdl/debug_req_gate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_harness_cfg.svh"

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dbg_req_i,
  input  logic debug_enable_i,
  output logic core_debug_req_o
);

  soc_harness_pkg::dly_cnt_t cnt_d;
  soc_harness_pkg::dly_cnt_t cnt_q;
  logic                      window_open;

  // ----------------------------------------
  // Boot window counter
  // ----------------------------------------
  // Counts down to zero, then holds
  assign window_open = (cnt_q == '0);
  assign cnt_d       = window_open ? cnt_q : cnt_q - 1'b1;

  // Only power-on reset restarts the window
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= soc_harness_pkg::dly_cnt_t'(`DBG_DELAY_CYCLES);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // ----------------------------------------
  // Request gating
  // ----------------------------------------
  // Lets the core run boot code before it can be halted
  assign core_debug_req_o = window_open & debug_enable_i & dbg_req_i;

  // The window never closes again before the next power-on reset
  a_window_stays_open : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    window_open |=> window_open
  );

endmodule

`default_nettype wire

/* hdl/main_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_harness_cfg.svh"

module main_sram (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  soc_harness_pkg::addr_t addr_i,
  input  soc_harness_pkg::strb_t be_i,
  input  soc_harness_pkg::data_t wdata_i,
  output soc_harness_pkg::data_t rdata_o
);

  // Byte offset bits below the word index
  localparam int unsigned off_w = $clog2(`STRB_W);

  soc_harness_pkg::sram_idx_t sram_idx;
  soc_harness_pkg::data_t     mem_q [`SRAM_WORDS];
  soc_harness_pkg::data_t     rdata_q;

  // Low address bits are ignored, accesses are full words
  assign sram_idx = addr_i[off_w +: $bits(soc_harness_pkg::sram_idx_t)];

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  // Contents survive both reset sources
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < `STRB_W; b++) begin
        if (be_i[b]) begin
          mem_q[sram_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read word appears the cycle after the request
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[sram_idx];
    end
  end

  assign rdata_o = rdata_q;

  // A write with no bytes enabled is a core bug
  a_write_has_bytes : assert property (
    @(posedge clk_i) (req_i && we_i) |-> (be_i != '0)
  );

endmodule

`default_nettype wire

/* hdl/soc_harness.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_harness (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ndmreset_i,
  input  logic                   debug_enable_i,
  input  logic                   dbg_req_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  soc_harness_pkg::addr_t addr_i,
  input  soc_harness_pkg::strb_t be_i,
  input  soc_harness_pkg::data_t wdata_i,
  output logic                   core_rst_no,
  output logic                   core_debug_req_o,
  output logic                   rsp_valid_o,
  output logic                   rsp_err_o,
  output soc_harness_pkg::data_t rdata_o
);

  logic                   sys_rst_n;
  logic                   rom_req;
  logic                   sram_req;
  soc_harness_pkg::data_t rom_rdata;
  soc_harness_pkg::data_t sram_rdata;

  // ----------------------------------------
  // Resets and debug
  // ----------------------------------------
  soc_reset_sync i_soc_reset_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_n  )
  );

  // Core sees the synchronised system reset
  assign core_rst_no = sys_rst_n;

  // Window is tied to power-on reset only
  debug_req_gate i_debug_req_gate (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .dbg_req_i        ( dbg_req_i        ),
    .debug_enable_i   ( debug_enable_i   ),
    .core_debug_req_o ( core_debug_req_o )
  );

  // ----------------------------------------
  // Memory bus
  // ----------------------------------------
  bus_addr_decode i_bus_addr_decode (
    .clk_i        ( clk_i       ),
    .rst_ni       ( sys_rst_n   ),
    .req_i        ( req_i       ),
    .we_i         ( we_i        ),
    .addr_i       ( addr_i      ),
    .rom_rdata_i  ( rom_rdata   ),
    .sram_rdata_i ( sram_rdata  ),
    .rom_req_o    ( rom_req     ),
    .sram_req_o   ( sram_req    ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_err_o    ( rsp_err_o   ),
    .rdata_o      ( rdata_o     )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( addr_i    ),
    .rdata_o ( rom_rdata )
  );

  // Write data and byte enables come straight from the port
  main_sram i_main_sram (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .we_i    ( we_i       ),
    .addr_i  ( addr_i     ),
    .be_i    ( be_i       ),
    .wdata_i ( wdata_i    ),
    .rdata_o ( sram_rdata )
  );

endmodule

`default_nettype wire

/* hdl/soc_harness_cfg.svh */
`ifndef SOC_HARNESS_CFG_SVH
`define SOC_HARNESS_CFG_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define ADDR_W 32
`define DATA_W 64
`define STRB_W 8

// ----------------------------------------
// Address map
// ----------------------------------------
// Boot ROM region and its distinct words
`define ROM_BASE  32'h0001_0000
`define ROM_LEN   32'h0001_0000
`define ROM_WORDS 16
`define ROM_SIG   32'hB007_0000

// GPIO block is not implemented, its 0x1000 bytes decode as unmapped
`define GPIO_BASE 32'h4000_0000

// Main memory
`define SRAM_BASE  32'h8000_0000
`define SRAM_WORDS 1024

// Boot window before debug requests reach the core
`define DBG_DELAY_CYCLES 50

`endif

/* hdl/soc_harness_pkg.sv */
`default_nettype none

`include "soc_harness_cfg.svh"

package soc_harness_pkg;

  // ----------------------------------------
  // Bus types
  // ----------------------------------------
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`STRB_W-1:0] strb_t;

  // ----------------------------------------
  // Memory indices and counters
  // ----------------------------------------
  // Word index into the boot ROM table
  typedef logic [$clog2(`ROM_WORDS)-1:0] rom_idx_t;

  // Word index into main memory
  typedef logic [$clog2(`SRAM_WORDS)-1:0] sram_idx_t;

  // Debug hold-off counter
  typedef logic [7:0] dly_cnt_t;

  // Target selected by the address map
  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_ROM,
    REGION_SRAM
  } region_e;

endpackage

`default_nettype wire

/* hdl/soc_reset_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_reset_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  // Power-on reset or debug-module reset request
  logic       rst_comb_n;
  logic [1:0] sync_q;

  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Assert asynchronously, release through two flops
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

`default_nettype wire

/* soc_harness.f */
+incdir+hdl
hdl/soc_harness_pkg.sv
hdl/soc_reset_sync.sv
hdl/debug_req_gate.sv
hdl/bus_addr_decode.sv
hdl/boot_rom.sv
hdl/main_sram.sv
hdl/soc_harness.sv
tb/tb_soc_harness.sv

/* tb/tb_soc_harness.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_harness_cfg.svh"

module tb_soc_harness;

  localparam int unsigned sram_bytes = `SRAM_WORDS * `STRB_W;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   ndmreset_i;
  logic                   debug_enable_i;
  logic                   dbg_req_i;
  logic                   req_i;
  logic                   we_i;
  soc_harness_pkg::addr_t addr_i;
  soc_harness_pkg::strb_t be_i;
  soc_harness_pkg::data_t wdata_i;
  logic                   core_rst_no;
  logic                   core_debug_req_o;
  logic                   rsp_valid_o;
  logic                   rsp_err_o;
  soc_harness_pkg::data_t rdata_o;

  int                     seed = 35384;

  // Reference model of main memory with the known bytes of each word
  soc_harness_pkg::data_t model_mem   [`SRAM_WORDS];
  soc_harness_pkg::strb_t model_known [`SRAM_WORDS];
  int unsigned            written_q   [$];

  // Values currently on the DUT inputs
  logic                   cur_req;
  logic                   cur_we;
  soc_harness_pkg::addr_t cur_addr;
  soc_harness_pkg::strb_t cur_be;
  soc_harness_pkg::data_t cur_wdata;
  logic                   cur_ndm;
  logic                   cur_dbg;
  logic                   cur_en;
  logic                   nxt_ndm;
  logic                   nxt_dbg;
  logic                   nxt_en;

  // Reset and debug window state and the expected response
  int                     rel_edges;
  int                     dbg_cnt;
  logic                   exp_valid;
  logic                   exp_err;
  soc_harness_pkg::data_t exp_rdata;
  soc_harness_pkg::data_t exp_mask;

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  soc_harness i_soc_harness (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .ndmreset_i       ( ndmreset_i       ),
    .debug_enable_i   ( debug_enable_i   ),
    .dbg_req_i        ( dbg_req_i        ),
    .req_i            ( req_i            ),
    .we_i             ( we_i             ),
    .addr_i           ( addr_i           ),
    .be_i             ( be_i             ),
    .wdata_i          ( wdata_i          ),
    .core_rst_no      ( core_rst_no      ),
    .core_debug_req_o ( core_debug_req_o ),
    .rsp_valid_o      ( rsp_valid_o      ),
    .rsp_err_o        ( rsp_err_o        ),
    .rdata_o          ( rdata_o          )
  );

  // ----------------------------------------
  // Checking
  // ----------------------------------------
  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      fail_stop($sformatf("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_outputs();
    check_val("rsp_valid_o", rsp_valid_o, exp_valid);
    if (exp_valid) begin
      check_val("rsp_err_o", rsp_err_o, exp_err);
      check_val("rdata_o", rdata_o & exp_mask, exp_rdata & exp_mask);
    end else begin
      check_val("rsp_err_o", rsp_err_o, 1'b0);
    end
    check_val("core_rst_no", core_rst_no, !cur_ndm && rel_edges >= 2);
    check_val("core_debug_req_o", core_debug_req_o, dbg_cnt == 0 && cur_dbg && cur_en);
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Expected response of an accepted request and the write into memory
  task automatic model_access();
    int unsigned idx;
    exp_valid = 1'b1;
    exp_err   = 1'b0;
    exp_rdata = '0;
    exp_mask  = '1;
    if (cur_addr >= `ROM_BASE && cur_addr < `ROM_BASE + `ROM_LEN) begin
      if (!cur_we) begin
        exp_rdata = {`ROM_SIG, 28'd0, cur_addr[6:3]};
      end
    end else if (cur_addr >= `SRAM_BASE && cur_addr < `SRAM_BASE + sram_bytes) begin
      idx = cur_addr[12:3];
      if (cur_we) begin
        for (int b = 0; b < `STRB_W; b++) begin
          if (cur_be[b]) begin
            model_mem[idx][b*8 +: 8] = cur_wdata[b*8 +: 8];
            model_known[idx][b]      = 1'b1;
          end
        end
      end else begin
        exp_rdata = model_mem[idx];
        exp_mask  = '0;
        for (int b = 0; b < `STRB_W; b++) begin
          if (model_known[idx][b]) exp_mask[b*8 +: 8] = 8'hff;
        end
      end
    end else begin
      exp_err = 1'b1;
    end
  endtask

  // Models the clock edge, drives new inputs and checks at the falling edge
  task automatic step(input logic req, input logic we, input soc_harness_pkg::addr_t addr,
                      input soc_harness_pkg::strb_t be, input soc_harness_pkg::data_t wdata);
    @(posedge clk_i);
    exp_valid = 1'b0;
    if (cur_req && !cur_ndm && rel_edges >= 2) model_access();
    if (cur_ndm) rel_edges = 0;
    else if (rel_edges < 2) rel_edges++;
    if (dbg_cnt > 0) dbg_cnt--;
    cur_req   = req;
    cur_we    = we;
    cur_addr  = addr;
    cur_be    = be;
    cur_wdata = wdata;
    cur_ndm   = nxt_ndm;
    cur_dbg   = nxt_dbg;
    cur_en    = nxt_en;
    req_i          <= req;
    we_i           <= we;
    addr_i         <= addr;
    be_i           <= be;
    wdata_i        <= wdata;
    ndmreset_i     <= nxt_ndm;
    dbg_req_i      <= nxt_dbg;
    debug_enable_i <= nxt_en;
    // ndmreset clears the system reset and the pending response at once
    if (cur_ndm) begin
      rel_edges = 0;
      exp_valid = 1'b0;
    end
    @(negedge clk_i);
    check_outputs();
  endtask

  task automatic idle();
    step(1'b0, 1'b0, '0, '0, '0);
  endtask

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic soc_harness_pkg::strb_t rand_be();
    soc_harness_pkg::strb_t be;
    be = soc_harness_pkg::strb_t'($random(seed));
    if (be == '0) be = 8'h01;
    return be;
  endfunction

  function automatic soc_harness_pkg::addr_t sram_addr(input int unsigned idx);
    return `SRAM_BASE + idx * 8 + ($random(seed) & 7);
  endfunction

  function automatic soc_harness_pkg::addr_t rom_addr();
    return `ROM_BASE + ($random(seed) & 32'hffff);
  endfunction

  // GPIO, below ROM, between ROM and SRAM, above SRAM
  function automatic soc_harness_pkg::addr_t unmapped_addr();
    case ($random(seed) & 3)
      0:       return `GPIO_BASE + ($random(seed) & 32'hfff);
      1:       return $random(seed) & 32'hfff8;
      2:       return `ROM_BASE + `ROM_LEN + ($random(seed) & 32'hffff);
      default: return `SRAM_BASE + sram_bytes + ($random(seed) & 32'hffff);
    endcase
  endfunction

  function automatic soc_harness_pkg::addr_t any_addr();
    case ($random(seed) & 3)
      0:       return rom_addr();
      1:       return unmapped_addr();
      default: return sram_addr($random(seed) & (`SRAM_WORDS - 1));
    endcase
  endfunction

  task automatic rand_request();
    step(1'b1, 1'($random(seed)), any_addr(), rand_be(), {$random(seed), $random(seed)});
  endtask

  task automatic shake_debug();
    nxt_dbg = 1'($random(seed));
    nxt_en  = 1'($random(seed));
  endtask

  task automatic read_back_written();
    foreach (written_q[i]) step(1'b1, 1'b0, sram_addr(written_q[i]), rand_be(), '0);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int unsigned            idx;
    int                     n;
    soc_harness_pkg::addr_t a;
    rst_ni         = 1'b0;
    ndmreset_i     = 1'b0;
    debug_enable_i = 1'b0;
    dbg_req_i      = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    {cur_req, cur_we, cur_ndm, cur_dbg, cur_en} = '0;
    {nxt_ndm, nxt_dbg, nxt_en} = '0;
    cur_addr  = '0;
    cur_be    = '0;
    cur_wdata = '0;
    for (int w = 0; w < `SRAM_WORDS; w++) model_known[w] = '0;
    for (int c = 0; c < 10; c++) @(posedge clk_i);
    rst_ni <= 1'b1;
    rel_edges = 0;
    dbg_cnt   = `DBG_DELAY_CYCLES;
    exp_valid = 1'b0;

    // Debug hold-off window with request and enable both high
    nxt_dbg = 1'b1;
    nxt_en  = 1'b1;
    n = 0;
    do begin
      idle();
      n++;
    end while (!core_debug_req_o && n < 2 * `DBG_DELAY_CYCLES);
    if (!core_debug_req_o) fail_stop("Timeout waiting for the debug request to pass the gate");
    nxt_dbg = 1'b0;
    nxt_en  = 1'b0;

    // SRAM writes with random byte enables, then reads
    for (int i = 0; i < 64; i++) begin
      idx = $random(seed) & (`SRAM_WORDS - 1);
      written_q.push_back(idx);
      step(1'b1, 1'b1, sram_addr(idx), rand_be(), {$random(seed), $random(seed)});
    end
    for (int i = 0; i < 64; i++) begin
      idx = written_q[($random(seed) & 32'h7fff_ffff) % written_q.size()];
      step(1'b1, 1'b0, sram_addr(idx), rand_be(), '0);
    end

    // ROM reads and a write that must change nothing
    for (int i = 0; i < 32; i++) step(1'b1, 1'b0, rom_addr(), rand_be(), '0);
    a = rom_addr();
    step(1'b1, 1'b0, a, rand_be(), '0);
    step(1'b1, 1'b1, a, rand_be(), {$random(seed), $random(seed)});
    step(1'b1, 1'b0, a, rand_be(), '0);

    // Unmapped space must leave SRAM intact
    for (int i = 0; i < 32; i++) begin
      step(1'b1, 1'($random(seed)), unmapped_addr(), rand_be(), {$random(seed), $random(seed)});
    end
    read_back_written();

    // Random gaps and back-to-back traffic
    for (int i = 0; i < 300; i++) begin
      shake_debug();
      if ($random(seed) & 1) rand_request();
      else idle();
    end

    // ndmreset pulse with traffic dropped during it
    idle();
    nxt_ndm = 1'b1;
    for (int i = 0; i < 6; i++) begin
      shake_debug();
      rand_request();
    end
    nxt_ndm = 1'b0;
    idle();
    n = 0;
    do begin
      shake_debug();
      idle();
      n++;
    end while (!core_rst_no && n < 10);
    if (!core_rst_no) fail_stop("Timeout waiting for core reset release after ndmreset");
    for (int i = 0; i < 20; i++) begin
      shake_debug();
      idle();
    end
    read_back_written();

    idle();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
